//--- rtl/fltr_defines.svh
`ifndef FLTR_DEFINES_SVH
`define FLTR_DEFINES_SVH

// pixel stream and tap window
`define FLTR_SAMPLE_W 8
`define FLTR_TAPS 7

// datapath widths
// coefficients fit in 9 bits, largest is 324
`define FLTR_COEF_W 9
`define FLTR_PROD_W 17
`define FLTR_SUM_W 20
`define FLTR_OUT_W 16

// output is sum[18:3], a divide by eight
`define FLTR_SHIFT 3

// kernel 0, the h4 set
`define FLTR_K0_C0 9'd14
`define FLTR_K0_C1 9'd43
`define FLTR_K0_C2 9'd80
`define FLTR_K0_C3 9'd324
`define FLTR_K0_C4 9'd80
`define FLTR_K0_C5 9'd43
`define FLTR_K0_C6 9'd14

// kernel 1, set c
`define FLTR_K1_C0 9'd4
`define FLTR_K1_C1 9'd42
`define FLTR_K1_C2 9'd163
`define FLTR_K1_C3 9'd255
`define FLTR_K1_C4 9'd163
`define FLTR_K1_C5 9'd42
`define FLTR_K1_C6 9'd4

// kernel 2, set d
// centre tap is zero
`define FLTR_K2_C0 9'd12
`define FLTR_K2_C1 9'd77
`define FLTR_K2_C2 9'd148
`define FLTR_K2_C3 9'd0
`define FLTR_K2_C4 9'd148
`define FLTR_K2_C5 9'd77
`define FLTR_K2_C6 9'd12

// kernel 3, set 3
`define FLTR_K3_C0 9'd9
`define FLTR_K3_C1 9'd56
`define FLTR_K3_C2 9'd109
`define FLTR_K3_C3 9'd0
`define FLTR_K3_C4 9'd109
`define FLTR_K3_C5 9'd56
`define FLTR_K3_C6 9'd9

`endif

//--- rtl/fltr_pkg.sv
`default_nettype none

`include "fltr_defines.svh"

package fltr_pkg;

	// one unsigned pixel of the stream
	typedef logic [`FLTR_SAMPLE_W-1:0] sample_t;

	// kernel bank select, travels with each sample
	typedef enum logic [1:0]
	{
		KERNEL_H4 = 2'd0,
		KERNEL_C  = 2'd1,
		KERNEL_D  = 2'd2,
		KERNEL_3  = 2'd3
	} kernel_sel_t;

endpackage

`default_nettype wire

//--- rtl/fltr_window.sv
`timescale 1ns/1ns
`default_nettype none

`include "fltr_defines.svh"

module fltr_window
	import fltr_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_valid,
	input  sample_t                               in_sample,
	input  kernel_sel_t                           in_kernel,
	output logic                                  win_valid,
	output logic [`FLTR_TAPS*`FLTR_SAMPLE_W-1:0]  win_taps,
	output kernel_sel_t                           win_kernel
);

	localparam int TAPS     = `FLTR_TAPS;
	localparam int SAMPLE_W = `FLTR_SAMPLE_W;
	localparam int WIN_W    = TAPS * SAMPLE_W;
	localparam int CNT_W    = $clog2(TAPS + 1);

	// the sample that brings the count to this value completes the window
	localparam logic [CNT_W-1:0] LAST_MISSING = CNT_W'(TAPS - 1);
	localparam logic [CNT_W-1:0] CNT_FULL     = CNT_W'(TAPS);

	// samples seen since reset, saturates at TAPS
	logic [CNT_W-1:0] fill_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fill_cnt <= '0;
		end
		else if (in_valid && (fill_cnt != CNT_FULL))
		begin
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// strobe once the new sample leaves seven taps in the window
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			win_valid <= 1'b0;
		end
		else
		begin
			win_valid <= in_valid && (fill_cnt >= LAST_MISSING);
		end
	end

	// delay line, newest sample enters the low byte
	// oldest drops off the top
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			win_taps   <= '0;
			win_kernel <= KERNEL_H4;
		end
		else if (in_valid)
		begin
			win_taps   <= {win_taps[WIN_W-SAMPLE_W-1:0], in_sample};
			win_kernel <= in_kernel;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fltr_compute.sv
`timescale 1ns/1ns
`default_nettype none

`include "fltr_defines.svh"

module fltr_compute
	import fltr_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  win_valid,
	input  logic [`FLTR_TAPS*`FLTR_SAMPLE_W-1:0]  win_taps,
	input  kernel_sel_t                           win_kernel,
	output logic                                  out_valid,
	output logic [`FLTR_OUT_W-1:0]                out_data
);

	localparam int TAPS     = `FLTR_TAPS;
	localparam int SAMPLE_W = `FLTR_SAMPLE_W;
	localparam int COEF_W   = `FLTR_COEF_W;
	localparam int PROD_W   = `FLTR_PROD_W;
	localparam int SUM_W    = `FLTR_SUM_W;
	localparam int OUT_W    = `FLTR_OUT_W;
	localparam int SHIFT    = `FLTR_SHIFT;

	// kernels are symmetric, so only taps 0 to 3 need a coefficient
	localparam int HALF = TAPS / 2 + 1;

	sample_t              tap [TAPS];
	logic [COEF_W-1:0]    coef_half [HALF];
	logic [PROD_W-1:0]    prod_d [TAPS];
	logic [PROD_W-1:0]    prod_q [TAPS];
	logic [SUM_W-1:0]     sum_d;
	logic [SUM_W-1:0]     sum_q;

	// valid flags for stages one and two
	logic                 prod_valid;
	logic                 sum_valid;

	// coefficient set for the item at the window output
	always_comb
	begin
		case (win_kernel)
			KERNEL_C:
			begin
				coef_half[0] = `FLTR_K1_C0;
				coef_half[1] = `FLTR_K1_C1;
				coef_half[2] = `FLTR_K1_C2;
				coef_half[3] = `FLTR_K1_C3;
			end
			KERNEL_D:
			begin
				coef_half[0] = `FLTR_K2_C0;
				coef_half[1] = `FLTR_K2_C1;
				coef_half[2] = `FLTR_K2_C2;
				coef_half[3] = `FLTR_K2_C3;
			end
			KERNEL_3:
			begin
				coef_half[0] = `FLTR_K3_C0;
				coef_half[1] = `FLTR_K3_C1;
				coef_half[2] = `FLTR_K3_C2;
				coef_half[3] = `FLTR_K3_C3;
			end
			default:
			begin
				// kernel 0, the h4 set
				coef_half[0] = `FLTR_K0_C0;
				coef_half[1] = `FLTR_K0_C1;
				coef_half[2] = `FLTR_K0_C2;
				coef_half[3] = `FLTR_K0_C3;
			end
		endcase
	end

	// tap 0 is the oldest sample, in the top byte
	// mirrored taps share one coefficient
	for (genvar i = 0; i < TAPS; i++)
	begin : g_tap
		localparam int MIRROR = (i < HALF) ? i : TAPS - 1 - i;

		assign tap[i] = win_taps[(TAPS-1-i)*SAMPLE_W +: SAMPLE_W];

		// unsigned product, 8 x 9 bits fits in 17
		assign prod_d[i] = {{(PROD_W-SAMPLE_W){1'b0}}, tap[i]}
			* {{(PROD_W-COEF_W){1'b0}}, coef_half[MIRROR]};
	end

	// adder tree over the registered products
	always_comb
	begin
		sum_d = '0;
		for (int i = 0; i < TAPS; i++)
		begin
			sum_d = sum_d + {{(SUM_W-PROD_W){1'b0}}, prod_q[i]};
		end
	end

	// stage one, products
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < TAPS; i++)
		begin
			prod_q[i] <= prod_d[i];
		end
	end

	// stage two, sum
	always_ff @(posedge clk)
	begin
		sum_q <= sum_d;
	end

	// stage three, scale down by eight
	always_ff @(posedge clk)
	begin
		out_data <= sum_q[SHIFT +: OUT_W];
	end

	// valid bit beside each stage
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
			out_valid  <= 1'b0;
		end
		else
		begin
			prod_valid <= win_valid;
			sum_valid  <= prod_valid;
			out_valid  <= sum_valid;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fltr_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "fltr_defines.svh"

module fltr_top
	import fltr_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  sample_t                 in_sample,
	input  kernel_sel_t             in_kernel,
	output logic                    out_valid,
	output logic [`FLTR_OUT_W-1:0]  out_data
);

	localparam int WIN_W = `FLTR_TAPS * `FLTR_SAMPLE_W;

	// window to compute
	logic              win_valid;
	logic [WIN_W-1:0]  win_taps;
	kernel_sel_t       win_kernel;

	// seven-tap delay line, one register stage
	fltr_window u_window
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.in_kernel  (in_kernel),
		.win_valid  (win_valid),
		.win_taps   (win_taps),
		.win_kernel (win_kernel)
	);

	// multiply, sum and scale, three stages
	fltr_compute u_compute
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.win_valid  (win_valid),
		.win_taps   (win_taps),
		.win_kernel (win_kernel),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

//--- test/fltr_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "fltr_defines.svh"

module fltr_checker
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic win_valid,
	input logic out_valid
);

	localparam int TAPS = `FLTR_TAPS;

	// input strobes since reset, saturates at TAPS
	logic [3:0] strobe_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			strobe_cnt <= '0;
		end
		else if (in_valid && (strobe_cnt != 4'(TAPS)))
		begin
			strobe_cnt <= strobe_cnt + 1'b1;
		end
	end

	// nothing comes out during reset
	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high while rst_n is low");

	// three compute stages, both directions
	a_compute_latency: assert property (@(posedge clk) disable iff (!rst_n)
		win_valid |-> ##3 out_valid)
		else $error("out_valid missing 3 cycles after win_valid");

	a_no_orphan_out: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(win_valid, 3))
		else $error("out_valid without win_valid 3 cycles earlier");

	// window needs seven samples first
	a_window_full: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (strobe_cnt == 4'(TAPS)))
		else $error("out_valid before seven input strobes");

endmodule

bind fltr_top fltr_checker u_checker
(
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.win_valid (win_valid),
	.out_valid (out_valid)
);

`default_nettype wire

//--- test/fltr_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fltr_defines.svh"

module fltr_tb
	import fltr_pkg::*;
();

	localparam int TAPS         = `FLTR_TAPS;
	localparam int OUT_W        = `FLTR_OUT_W;
	localparam int SHIFT        = `FLTR_SHIFT;
	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 3;
	// in_valid of the newest tap to out_valid
	localparam int PIPE_LAT     = 4;
	localparam int DRAIN_CYCLES = PIPE_LAT + 4;
	localparam int FIXED_GAP    = 2;
	localparam int MAX_GAP      = 3;

	// sample patterns
	localparam int PAT_CONST   = 0;
	localparam int PAT_RAMP    = 1;
	localparam int PAT_IMPULSE = 2;
	localparam int PAT_RANDOM  = 3;

	// kernel modes beyond the four fixed ones
	localparam int KSEL_SWEEP  = 4;
	localparam int KSEL_RANDOM = 5;

	// idle cycles after each sample
	localparam int GAP_NONE   = 0;
	localparam int GAP_FIXED  = 1;
	localparam int GAP_RANDOM = 2;

	localparam int NUM_TESTS = 8;

	string test_name [NUM_TESTS] = '{"const_k0", "const_k1", "const_k2", "const_k3_gaps",
		"impulse_k1", "ramp_k2_gaps", "kernel_sweep", "random_all"};
	int test_count   [NUM_TESTS] = '{10, 10, 10, 10, 14, 20, 24, 80};
	int test_pattern [NUM_TESTS] = '{PAT_CONST, PAT_CONST, PAT_CONST, PAT_CONST,
		PAT_IMPULSE, PAT_RAMP, PAT_RANDOM, PAT_RANDOM};
	int test_value   [NUM_TESTS] = '{255, 255, 200, 100, 255, 5, 0, 0};
	int test_kernel  [NUM_TESTS] = '{0, 1, 2, 3, 1, 2, KSEL_SWEEP, KSEL_RANDOM};
	int test_gap     [NUM_TESTS] = '{GAP_NONE, GAP_NONE, GAP_NONE, GAP_FIXED,
		GAP_NONE, GAP_FIXED, GAP_NONE, GAP_RANDOM};
	// reset before the test while earlier results are still in flight
	int test_reset   [NUM_TESTS] = '{0, 0, 0, 1, 0, 0, 0, 0};

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	sample_t           in_sample;
	kernel_sel_t       in_kernel;
	logic              out_valid;
	logic [OUT_W-1:0]  out_data;

	// reference model state with tap 0 the oldest
	int                hist [TAPS];
	int                seen;
	logic [OUT_W-1:0]  exp_q [$];
	int                exp_cycle_q [$];
	string             exp_name_q [$];

	integer            seed = 32'he00a;
	int                cycle = 0;
	int                cycle_limit = 0;

	fltr_top dut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.in_kernel (in_kernel),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// full seven-tap coefficient table per kernel
	function automatic int coef_of(input kernel_sel_t k, input int i);
		logic [`FLTR_COEF_W-1:0] c [TAPS];
		case (k)
			KERNEL_C:
				c = '{`FLTR_K1_C0, `FLTR_K1_C1, `FLTR_K1_C2, `FLTR_K1_C3,
					`FLTR_K1_C4, `FLTR_K1_C5, `FLTR_K1_C6};
			KERNEL_D:
				c = '{`FLTR_K2_C0, `FLTR_K2_C1, `FLTR_K2_C2, `FLTR_K2_C3,
					`FLTR_K2_C4, `FLTR_K2_C5, `FLTR_K2_C6};
			KERNEL_3:
				c = '{`FLTR_K3_C0, `FLTR_K3_C1, `FLTR_K3_C2, `FLTR_K3_C3,
					`FLTR_K3_C4, `FLTR_K3_C5, `FLTR_K3_C6};
			default:
				c = '{`FLTR_K0_C0, `FLTR_K0_C1, `FLTR_K0_C2, `FLTR_K0_C3,
					`FLTR_K0_C4, `FLTR_K0_C5, `FLTR_K0_C6};
		endcase
		return int'(c[i]);
	endfunction

	function automatic int kernel_sum(input kernel_sel_t k);
		int i;
		int total;
		total = 0;
		for (i = 0; i < TAPS; i++)
			total += coef_of(k, i);
		return total;
	endfunction

	// worst case length of the whole table with random gaps at their maximum
	function automatic int limit_for_tests();
		int t;
		int gap;
		int total;
		total = RESET_CYCLES + DRAIN_CYCLES + 50;
		for (t = 0; t < NUM_TESTS; t++)
		begin
			gap = (test_gap[t] == GAP_NONE) ? 0 :
				((test_gap[t] == GAP_FIXED) ? FIXED_GAP : MAX_GAP);
			total += test_count[t] * (1 + gap);
			if (test_reset[t] != 0)
				total += RESET_CYCLES + 1;
		end
		return total;
	endfunction

	// table against the known 255 x kernel 0 result and symmetry
	task automatic check_kernel_table();
		int k;
		int i;
		int got;
		got = (255 * kernel_sum(KERNEL_H4)) >> SHIFT;
		assert (got == 19061)
		else fail_run($sformatf("ERROR kernel_table: expected %0d, actual %0d", 19061, got));
		for (k = 0; k < 4; k++)
			for (i = 0; i < TAPS / 2; i++)
				assert (coef_of(kernel_sel_t'(2'(k)), i)
					== coef_of(kernel_sel_t'(2'(k)), TAPS - 1 - i))
				else fail_run($sformatf("kernel %0d is not symmetric at tap %0d", k, i));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// empty window and nothing expected
	task automatic clear_model();
		int i;
		seen = 0;
		for (i = 0; i < TAPS; i++)
			hist[i] = 0;
		exp_q.delete();
		exp_cycle_q.delete();
		exp_name_q.delete();
	endtask

	// results still in the pipeline are lost in the reset
	task automatic reset_midstream();
		next_cycle();
		in_valid = 1'b0;
		rst_n    = 1'b0;
		clear_model();
		repeat (RESET_CYCLES) next_cycle();
		rst_n = 1'b1;
	endtask

	// shift one sample into the model and queue a result once the window is full
	task automatic model_sample(input sample_t s, input kernel_sel_t k, input string name);
		int i;
		int acc;
		for (i = 0; i < TAPS - 1; i++)
			hist[i] = hist[i + 1];
		hist[TAPS - 1] = int'(s);
		if (seen < TAPS)
			seen++;
		if (seen == TAPS)
		begin
			acc = 0;
			for (i = 0; i < TAPS; i++)
				acc += hist[i] * coef_of(k, i);
			exp_q.push_back(OUT_W'(acc >> SHIFT));
			exp_cycle_q.push_back(cycle + PIPE_LAT);
			exp_name_q.push_back(name);
		end
	endtask

	task automatic run_test(input int t);
		int i;
		int g;
		int gaps;
		sample_t s;
		kernel_sel_t k;
		for (i = 0; i < test_count[t]; i++)
		begin
			case (test_pattern[t])
				PAT_CONST:   s = sample_t'(test_value[t]);
				PAT_RAMP:    s = sample_t'(test_value[t] + i * 17);
				PAT_IMPULSE: s = (i == TAPS) ? sample_t'(test_value[t]) : '0;
				default:     s = sample_t'($random(seed));
			endcase
			if (test_kernel[t] == KSEL_SWEEP)
				k = kernel_sel_t'(2'(i));
			else if (test_kernel[t] == KSEL_RANDOM)
				k = kernel_sel_t'(2'($random(seed)));
			else
				k = kernel_sel_t'(2'(test_kernel[t]));

			next_cycle();
			in_valid  = 1'b1;
			in_sample = s;
			in_kernel = k;
			model_sample(s, k, test_name[t]);

			case (test_gap[t])
				GAP_FIXED:  gaps = FIXED_GAP;
				GAP_RANDOM: gaps = $random(seed) & 3;
				default:    gaps = 0;
			endcase
			// in_valid gates the junk on the data lines while idle
			for (g = 0; g < gaps; g++)
			begin
				next_cycle();
				in_valid  = 1'b0;
				in_sample = sample_t'($random(seed));
			end
		end
	endtask

	// cycle count and timeout
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle_limit > 0)
			assert (cycle < cycle_limit)
			else fail_run($sformatf("timeout, no end of test after %0d cycles", cycle));
	end

	// scoreboard sampled away from the rising edge
	always @(negedge clk)
	begin
		logic [OUT_W-1:0] exp_data;
		int exp_cycle;
		string name;
		if (rst_n && out_valid)
		begin
			assert (exp_q.size() != 0)
			begin
				exp_data  = exp_q.pop_front();
				exp_cycle = exp_cycle_q.pop_front();
				name      = exp_name_q.pop_front();
				assert (out_data == exp_data)
				else fail_run($sformatf("ERROR %s: expected %0d, actual %0d",
					name, exp_data, out_data));
				assert (cycle == exp_cycle)
				else fail_run($sformatf("ERROR %s: expected output in cycle %0d, actual %0d",
					name, exp_cycle, cycle));
			end
			else fail_run("out_valid went high with no result expected");
		end
	end

	initial
	begin
		int t;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_sample = '0;
		in_kernel = KERNEL_H4;
		clear_model();
		cycle_limit = limit_for_tests();
		check_kernel_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		for (t = 0; t < NUM_TESTS; t++)
		begin
			if (test_reset[t] != 0)
				reset_midstream();
			run_test(t);
		end
		next_cycle();
		in_valid = 1'b0;

		// last results leave the pipeline after PIPE_LAT cycles
		repeat (DRAIN_CYCLES) @(posedge clk);
		if (exp_q.size() == 0)
		begin
			$display("NO ERRORS");
			$finish;
		end
		else
		begin
			fail_run($sformatf("%0d expected results never came out", exp_q.size()));
		end
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/fltr_pkg.sv
rtl/fltr_window.sv
rtl/fltr_compute.sv
rtl/fltr_top.sv
test/fltr_checker.sv
test/fltr_tb.sv

//--- Makefile
TOP = fltr_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f rtl/*.sv rtl/*.svh test/*.sv
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	rm -f sim.log
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
